//--- mem_pkg.sv
// ****************************************
// Shared widths, depths and op codes
// State encodings for arbiter and controller
// ****************************************

`default_nettype none

package mem_pkg;

  // Cache line and address widths
  localparam int cl_width       = 512;
  // Raw address counts lines, not bytes
  localparam int addr_width     = 32;

  // Line store depth, 256 lines
  localparam int mem_depth_log2 = 8;
  localparam int mem_depth      = 1 << mem_depth_log2;

  // Requester ports on the arbiter
  localparam int num_src        = 3;
  localparam int src_sel_width  = 2;

  // Op codes, code 3 behaves as op_none
  localparam logic [1:0] op_none  = 2'd0;
  localparam logic [1:0] op_read  = 2'd1;
  localparam logic [1:0] op_write = 2'd2;

  // Arbiter states
  localparam logic [1:0] arb_idle = 2'd0;
  localparam logic [1:0] arb_busy = 2'd1;
  localparam logic [1:0] arb_gap  = 2'd2;

  // Controller states
  localparam logic [1:0] ctrl_idle    = 2'd0;
  localparam logic [1:0] ctrl_access  = 2'd1;
  localparam logic [1:0] ctrl_rd_wait = 2'd2;
  localparam logic [1:0] ctrl_done    = 2'd3;

endpackage

`default_nettype wire

//--- line_store.sv
// ****************************************
// Single-port line memory, 256 x 512 bits
// Synchronous write, registered read data
// ****************************************

`default_nettype none

module line_store
  import mem_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      mem_we,
  input  wire logic [mem_depth_log2-1:0] mem_addr,
  input  wire logic [cl_width-1:0]       mem_wdata,
  output logic      [cl_width-1:0]       mem_rdata
);

  // ****************************************
  // Storage
  // ****************************************

  // Contents start undefined, nothing clears them
  logic [cl_width-1:0] mem_array [mem_depth];

  // Write port
  // One line per cycle when mem_we is high
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem_array[mem_addr] <= mem_wdata;
    end
  end

  // ****************************************
  // Read port
  // ****************************************

  // Read data lands one cycle after the address
  // Runs every cycle, the controller decides when to use it
  // On a write cycle this returns the old line
  always_ff @(posedge clk) begin
    mem_rdata <= mem_array[mem_addr];
  end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// ****************************************
// Round-robin arbiter, three requesters
// Forwards the owner's op to the controller
// Steers tx_done and rd_valid to the owner
// ****************************************

`default_nettype none

module mem_arbiter
  import mem_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Source 1, instruction fetch
  input  wire logic [1:0]            op_src1,
  input  wire logic [addr_width-1:0] raw_address_src1,
  input  wire logic [cl_width-1:0]   common_data_bus_read_in_src1,
  output logic      [cl_width-1:0]   common_data_bus_write_out_src1,
  output logic                       tx_done_src1,
  output logic                       rd_valid_src1,
  // Source 2, data port
  input  wire logic [1:0]            op_src2,
  input  wire logic [addr_width-1:0] raw_address_src2,
  input  wire logic [cl_width-1:0]   common_data_bus_read_in_src2,
  output logic      [cl_width-1:0]   common_data_bus_write_out_src2,
  output logic                       tx_done_src2,
  output logic                       rd_valid_src2,
  // Source 3, MMIO
  input  wire logic [1:0]            op_src3,
  input  wire logic [addr_width-1:0] raw_address_src3,
  input  wire logic [cl_width-1:0]   common_data_bus_read_in_src3,
  output logic      [cl_width-1:0]   common_data_bus_write_out_src3,
  output logic                       tx_done_src3,
  output logic                       rd_valid_src3,
  // Controller side
  output logic      [1:0]            op,
  output logic      [addr_width-1:0] raw_address,
  output logic      [cl_width-1:0]   common_data_bus_read_in,
  input  wire logic [cl_width-1:0]   common_data_bus_write_out,
  input  wire logic                  tx_done,
  input  wire logic                  rd_valid
);

  logic [1:0]               state;
  // Encoded last grant, also selects the forwarded request
  logic [src_sel_width-1:0] last_grant;
  // One-hot owner, high only while a transfer is in flight
  logic [num_src-1:0]       owner_oh;
  logic [num_src-1:0]       req_vec;
  logic                     req_found;
  logic [src_sel_width-1:0] next_owner;

  // Requests gathered into arrays for indexing
  logic [1:0]            op_req   [num_src];
  logic [addr_width-1:0] addr_req [num_src];
  logic [cl_width-1:0]   data_req [num_src];

  assign op_req[0]   = op_src1;
  assign op_req[1]   = op_src2;
  assign op_req[2]   = op_src3;
  assign addr_req[0] = raw_address_src1;
  assign addr_req[1] = raw_address_src2;
  assign addr_req[2] = raw_address_src3;
  assign data_req[0] = common_data_bus_read_in_src1;
  assign data_req[1] = common_data_bus_read_in_src2;
  assign data_req[2] = common_data_bus_read_in_src3;

  // Only read and write count as requests, code 3 is dropped here
  always_comb begin
    for (int n = 0; n < num_src; n++) begin
      req_vec[n] = (op_req[n] == op_read) || (op_req[n] == op_write);
    end
  end

  // ****************************************
  // Round-robin pick
  // ****************************************

  // Scan starts one past the last grant and wraps around
  always_comb begin : pick_next
    int cand;
    req_found  = 1'b0;
    next_owner = last_grant;
    for (int i = 1; i <= num_src; i++) begin
      cand = (int'(last_grant) + i) % num_src;
      if (!req_found && req_vec[cand]) begin
        req_found  = 1'b1;
        next_owner = cand[src_sel_width-1:0];
      end
    end
  end

  // Idle -> busy on a grant, busy -> gap on tx_done, gap -> idle
  // Gap lets the owner's op_none settle before the next scan
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= arb_idle;
      // Pointer at source 3 so source 1 wins first
      last_grant <= src_sel_width'(num_src - 1);
      owner_oh   <= '0;
    end else begin
      case (state)
        arb_idle: begin
          if (req_found) begin
            last_grant <= next_owner;
            owner_oh   <= num_src'(1) << next_owner;
            state      <= arb_busy;
          end
        end
        arb_busy: begin
          if (tx_done) begin
            owner_oh <= '0;
            state    <= arb_gap;
          end
        end
        arb_gap: state <= arb_idle;
        default: state <= arb_idle;
      endcase
    end
  end

  // ****************************************
  // Forward and return paths
  // ****************************************

  // Controller sees op_none while idle or in the gap
  always_comb begin
    op                      = op_none;
    raw_address             = '0;
    common_data_bus_read_in = '0;
    if (state == arb_busy) begin
      op                      = op_req[last_grant];
      raw_address             = addr_req[last_grant];
      common_data_bus_read_in = data_req[last_grant];
    end
  end

  // Response pulses go to the owner only, other ports see zeros
  assign tx_done_src1 = owner_oh[0] & tx_done;
  assign tx_done_src2 = owner_oh[1] & tx_done;
  assign tx_done_src3 = owner_oh[2] & tx_done;

  assign rd_valid_src1 = owner_oh[0] & rd_valid;
  assign rd_valid_src2 = owner_oh[1] & rd_valid;
  assign rd_valid_src3 = owner_oh[2] & rd_valid;

  assign common_data_bus_write_out_src1 = owner_oh[0] ? common_data_bus_write_out : '0;
  assign common_data_bus_write_out_src2 = owner_oh[1] ? common_data_bus_write_out : '0;
  assign common_data_bus_write_out_src3 = owner_oh[2] ? common_data_bus_write_out : '0;

endmodule

`default_nettype wire

//--- mem_ctrl.sv
// ****************************************
// Memory controller, one line per op
// Adds the address offset, wraps to depth
// Pulses tx_done, and rd_valid for reads
// ****************************************

`default_nettype none

module mem_ctrl
  import mem_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // Request from the arbiter
  input  wire logic [1:0]                op,
  input  wire logic [addr_width-1:0]     raw_address,
  input  wire logic [addr_width-1:0]     address_offset,
  input  wire logic [cl_width-1:0]       common_data_bus_read_in,
  // Response to the arbiter
  output logic      [cl_width-1:0]       common_data_bus_write_out,
  output logic                           tx_done,
  output logic                           rd_valid,
  // Line store port
  output logic                           mem_we,
  output logic      [mem_depth_log2-1:0] mem_addr,
  output logic      [cl_width-1:0]       mem_wdata,
  input  wire logic [cl_width-1:0]       mem_rdata
);

  logic [1:0]                state;
  logic [1:0]                op_q;
  logic                      op_valid;

  // Payload captured at acceptance
  logic [addr_width-1:0]     addr_sum;
  logic [mem_depth_log2-1:0] addr_q;
  logic [cl_width-1:0]       wdata_q;
  logic [cl_width-1:0]       rdata_q;

  // Code 3 falls out here and is treated as op_none
  assign op_valid = (op == op_read) || (op == op_write);

  // Corrected address, upper bits dropped on the register
  assign addr_sum = raw_address + address_offset;

  // ****************************************
  // Control FSM
  // ****************************************

  // idle    wait for a valid op, latch it
  // access  drive the line store for one cycle
  // rd_wait store read data on its way back
  // done    tx_done cycle, then back to idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ctrl_idle;
      op_q  <= op_none;
    end else begin
      case (state)
        ctrl_idle: begin
          if (op_valid) begin
            op_q  <= op;
            state <= ctrl_access;
          end
        end
        ctrl_access: begin
          // Write lands on this edge, a read still needs its data
          if (op_q == op_read) begin
            state <= ctrl_rd_wait;
          end else begin
            state <= ctrl_done;
          end
        end
        ctrl_rd_wait: state <= ctrl_done;
        ctrl_done:    state <= ctrl_idle;
        default:      state <= ctrl_idle;
      endcase
    end
  end

  // ****************************************
  // Datapath
  // ****************************************

  // Address and write data, captured with the op
  always_ff @(posedge clk) begin
    if (state == ctrl_idle && op_valid) begin
      addr_q  <= addr_sum[mem_depth_log2-1:0];
      wdata_q <= common_data_bus_read_in;
    end
  end

  // Returned line held until the next read
  always_ff @(posedge clk) begin
    if (state == ctrl_rd_wait) begin
      rdata_q <= mem_rdata;
    end
  end

  // Store port, write enable only in the access cycle
  assign mem_we    = (state == ctrl_access) && (op_q == op_write);
  assign mem_addr  = addr_q;
  assign mem_wdata = wdata_q;

  // Completion pulses, both come out of the done state
  assign tx_done  = (state == ctrl_done);
  assign rd_valid = (state == ctrl_done) && (op_q == op_read);

  assign common_data_bus_write_out = rdata_q;

endmodule

`default_nettype wire

//--- mem_subsys_top.sv
// ****************************************
// Memory subsystem top level
// Arbiter, controller and line store
// ****************************************

`default_nettype none

module mem_subsys_top
  import mem_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // Software-set offset, sampled when an op is accepted
  input  wire logic [addr_width-1:0] address_offset,
  // Source 1, instruction fetch
  input  wire logic [1:0]            op_src1,
  input  wire logic [addr_width-1:0] raw_address_src1,
  input  wire logic [cl_width-1:0]   common_data_bus_read_in_src1,
  output logic      [cl_width-1:0]   common_data_bus_write_out_src1,
  output logic                       tx_done_src1,
  output logic                       rd_valid_src1,
  // Source 2, data port
  input  wire logic [1:0]            op_src2,
  input  wire logic [addr_width-1:0] raw_address_src2,
  input  wire logic [cl_width-1:0]   common_data_bus_read_in_src2,
  output logic      [cl_width-1:0]   common_data_bus_write_out_src2,
  output logic                       tx_done_src2,
  output logic                       rd_valid_src2,
  // Source 3, MMIO
  input  wire logic [1:0]            op_src3,
  input  wire logic [addr_width-1:0] raw_address_src3,
  input  wire logic [cl_width-1:0]   common_data_bus_read_in_src3,
  output logic      [cl_width-1:0]   common_data_bus_write_out_src3,
  output logic                       tx_done_src3,
  output logic                       rd_valid_src3
);

  // Arbiter to controller
  logic [1:0]                op;
  logic [addr_width-1:0]     raw_address;
  logic [cl_width-1:0]       common_data_bus_read_in;
  logic [cl_width-1:0]       common_data_bus_write_out;
  logic                      tx_done;
  logic                      rd_valid;

  // Controller to line store
  logic                      mem_we;
  logic [mem_depth_log2-1:0] mem_addr;
  logic [cl_width-1:0]       mem_wdata;
  logic [cl_width-1:0]       mem_rdata;

  // Requesters share one controller port
  mem_arbiter arb0 (
    .clk                            (clk),
    .rst_n                          (rst_n),
    .op_src1                        (op_src1),
    .raw_address_src1               (raw_address_src1),
    .common_data_bus_read_in_src1   (common_data_bus_read_in_src1),
    .common_data_bus_write_out_src1 (common_data_bus_write_out_src1),
    .tx_done_src1                   (tx_done_src1),
    .rd_valid_src1                  (rd_valid_src1),
    .op_src2                        (op_src2),
    .raw_address_src2               (raw_address_src2),
    .common_data_bus_read_in_src2   (common_data_bus_read_in_src2),
    .common_data_bus_write_out_src2 (common_data_bus_write_out_src2),
    .tx_done_src2                   (tx_done_src2),
    .rd_valid_src2                  (rd_valid_src2),
    .op_src3                        (op_src3),
    .raw_address_src3               (raw_address_src3),
    .common_data_bus_read_in_src3   (common_data_bus_read_in_src3),
    .common_data_bus_write_out_src3 (common_data_bus_write_out_src3),
    .tx_done_src3                   (tx_done_src3),
    .rd_valid_src3                  (rd_valid_src3),
    .op                             (op),
    .raw_address                    (raw_address),
    .common_data_bus_read_in        (common_data_bus_read_in),
    .common_data_bus_write_out      (common_data_bus_write_out),
    .tx_done                        (tx_done),
    .rd_valid                       (rd_valid)
  );

  // One op at a time into the line store
  mem_ctrl ctrl0 (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .op                        (op),
    .raw_address               (raw_address),
    .address_offset            (address_offset),
    .common_data_bus_read_in   (common_data_bus_read_in),
    .common_data_bus_write_out (common_data_bus_write_out),
    .tx_done                   (tx_done),
    .rd_valid                  (rd_valid),
    .mem_we                    (mem_we),
    .mem_addr                  (mem_addr),
    .mem_wdata                 (mem_wdata),
    .mem_rdata                 (mem_rdata)
  );

  line_store store0 (
    .clk       (clk),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// ****************************************
// Testbench clock and reset
// 10 ns clock, rst_n low for 16 cycles
// ****************************************

`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Reset released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
// ****************************************
// Testbench for the memory subsystem
// LFSR stimulus on three requester ports
// Line model keyed by corrected address
// ****************************************

`default_nettype none

module tb_mem_subsys
  import mem_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_cycles = 200;
  localparam logic [31:0] lfsr_seed = 32'h4c6d;

  logic clk;
  logic rst_n;
  logic [addr_width-1:0] address_offset;
  logic [1:0]            op_drv    [1:3];
  logic [addr_width-1:0] addr_drv  [1:3];
  logic [cl_width-1:0]   wdata_drv [1:3];
  logic [cl_width-1:0]   rdata_w   [1:3];
  logic [3:1]            tx_done_v;
  logic [3:1]            rd_valid_v;

  // Port has an op outstanding
  bit   busy [1:3];
  int   errors;
  int   checks;
  logic [31:0] lfsr_state;
  // Model of the line store, corrected address to line
  logic [cl_width-1:0] model [int];

  tb_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

  mem_subsys_top dut0 (
    .clk(clk), .rst_n(rst_n), .address_offset(address_offset),
    .op_src1(op_drv[1]), .raw_address_src1(addr_drv[1]),
    .common_data_bus_read_in_src1(wdata_drv[1]),
    .common_data_bus_write_out_src1(rdata_w[1]),
    .tx_done_src1(tx_done_v[1]), .rd_valid_src1(rd_valid_v[1]),
    .op_src2(op_drv[2]), .raw_address_src2(addr_drv[2]),
    .common_data_bus_read_in_src2(wdata_drv[2]),
    .common_data_bus_write_out_src2(rdata_w[2]),
    .tx_done_src2(tx_done_v[2]), .rd_valid_src2(rd_valid_v[2]),
    .op_src3(op_drv[3]), .raw_address_src3(addr_drv[3]),
    .common_data_bus_read_in_src3(wdata_drv[3]),
    .common_data_bus_write_out_src3(rdata_w[3]),
    .tx_done_src3(tx_done_v[3]), .rd_valid_src3(rd_valid_v[3])
  );

  // ****************************************
  // Random numbers
  // ****************************************

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [cl_width-1:0] rand_bits(input int n);
    logic [cl_width-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[cl_width-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Line address bits 7:6 carry the port number, so bands stay disjoint
  function automatic logic [31:0] band_addr(input int p);
    logic [cl_width-1:0] r;
    r = rand_bits(30);
    return {r[29:6], 2'(p), r[5:0]};
  endfunction

  task automatic finish_run();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // ****************************************
  // One transfer on port p
  // ****************************************

  task automatic run_txn(input int p, input logic [1:0] o, input logic [31:0] a,
                         input logic [cl_width-1:0] d);
    int cyc;
    int others;
    bit got;
    int key;
    @(posedge clk);
    key = int'(8'(a + address_offset));
    op_drv[p]    <= o;
    addr_drv[p]  <= a;
    wdata_drv[p] <= d;
    busy[p] = 1'b1;
    cyc = 0;
    others = 0;
    got = 1'b0;
    while (!got && cyc < timeout_cycles) begin
      @(posedge clk);
      cyc++;
      if (tx_done_v[p]) begin
        got = 1'b1;
      end else begin
        // Transfers served on other ports while this one waits
        others += int'(tx_done_v[1]) + int'(tx_done_v[2]) + int'(tx_done_v[3]);
      end
    end
    if (!got) begin
      errors++;
      $display("Timeout: port %0d got no tx_done within %0d cycles", p, timeout_cycles);
      finish_run();
    end else begin
      op_drv[p] <= op_none;
      busy[p] = 1'b0;
      checks++;
      if (others > 2) begin
        errors++;
        $display("Port %0d waited through %0d transfers of other ports", p, others);
      end
      if (o == op_write) begin
        if (rd_valid_v[p]) begin
          errors++;
          $display("[ERROR] rd_valid_src%0d got %h exp %h on a write", p, rd_valid_v[p], 1'b0);
        end
        model[key] = d;
      end else if (!rd_valid_v[p]) begin
        errors++;
        $display("[ERROR] rd_valid_src%0d got %h exp %h on a read", p, rd_valid_v[p], 1'b1);
      end else if (!model.exists(key)) begin
        errors++;
        $display("Port %0d read line %0d that was never written", p, key);
      end else if (rdata_w[p] !== model[key]) begin
        errors++;
        $display("[ERROR] common_data_bus_write_out_src%0d got %h exp %h",
                 p, rdata_w[p], model[key]);
      end
    end
  endtask

  // Writes to random lines, then reads all of them back
  task automatic write_read_back(input int p, input int n);
    logic [31:0] written[$];
    logic [31:0] a;
    for (int i = 0; i < n; i++) begin
      a = band_addr(p);
      run_txn(p, op_write, a, rand_bits(cl_width));
      written.push_back(a);
    end
    foreach (written[i]) begin
      run_txn(p, op_read, written[i], '0);
    end
  endtask

  // Random mix, a read only targets a line this port wrote
  task automatic port_traffic(input int p, input int n);
    logic [31:0] written[$];
    logic [cl_width-1:0] r;
    logic [31:0] a;
    int idx;
    for (int i = 0; i < n; i++) begin
      r = rand_bits(1);
      if (r[0] && written.size() > 0) begin
        r = rand_bits(6);
        idx = int'(r[5:0]) % written.size();
        run_txn(p, op_read, written[idx], '0);
      end else begin
        a = band_addr(p);
        run_txn(p, op_write, a, rand_bits(cl_width));
        written.push_back(a);
      end
    end
  endtask

  // Idle code held for 50 cycles must stay unanswered
  task automatic hold_idle(input int p, input logic [1:0] o);
    @(posedge clk);
    op_drv[p] <= o;
    repeat (50) begin
      @(posedge clk);
      checks++;
      if (tx_done_v[p]) begin
        errors++;
        $display("[ERROR] tx_done_src%0d got %h exp %h under op %h", p, tx_done_v[p], 1'b0, o);
      end
    end
    op_drv[p] <= op_none;
  endtask

  // Pulse on a port with nothing outstanding, checked mid-cycle
  always @(negedge clk) begin
    for (int p = 1; p <= num_src; p++) begin
      if ((tx_done_v[p] || rd_valid_v[p]) && !busy[p]) begin
        errors++;
        $display("Response pulse on port %0d with no op outstanding", p);
      end
    end
  end

  // ****************************************
  // Test sequence
  // ****************************************

  initial begin
    int cyc;
    logic [31:0] a;
    logic [31:0] a2;
    logic [7:0]  caddr;
    errors = 0;
    checks = 0;
    lfsr_state = lfsr_seed;
    address_offset = '0;
    for (int p = 1; p <= num_src; p++) begin
      op_drv[p] = op_none;
      addr_drv[p] = '0;
      wdata_drv[p] = '0;
      busy[p] = 1'b0;
    end
    cyc = 0;
    while (rst_n !== 1'b1 && cyc < 100) begin
      @(posedge clk);
      cyc++;
    end
    if (rst_n !== 1'b1) begin
      errors++;
      $display("Timeout: reset never released");
      finish_run();
    end else begin
      repeat (5) @(posedge clk);
      // Single port write and read back
      for (int p = 1; p <= num_src; p++) begin
        write_read_back(p, 8);
      end
      // All ports at once, also exercises fairness
      @(posedge clk);
      address_offset <= 32'd17;
      fork
        port_traffic(1, 60);
        port_traffic(2, 60);
        port_traffic(3, 60);
      join
      // Offset past 256 lines, then read through another offset
      @(posedge clk);
      address_offset <= 32'h0000_01c5;
      a = band_addr(1);
      caddr = 8'(a + 32'h0000_01c5);
      run_txn(1, op_write, a, rand_bits(cl_width));
      @(posedge clk);
      address_offset <= 32'hffff_fff3;
      a2 = band_addr(2);
      a2[7:0] = caddr - 8'hf3;
      run_txn(2, op_read, a2, '0);
      for (int p = 1; p <= num_src; p++) begin
        write_read_back(p, 4);
      end
      // Idle codes
      hold_idle(2, op_none);
      hold_idle(3, 2'd3);
      repeat (5) @(posedge clk);
      finish_run();
    end
  end

endmodule

`default_nettype wire

//--- flist.f
mem_pkg.sv
line_store.sv
mem_arbiter.sv
mem_ctrl.sv
mem_subsys_top.sv
tb_clk_gen.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_subsys -f flist.f \
  --Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }

grep -qx "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
